// ==== src/hwce_pkg.sv ====
// hwce_pkg: widths, port counts, register map, engine-state codes, tcdm and cfg structs
`default_nettype none

package hwce_pkg;

  // cluster memory interface
  localparam int TCDM_ADDR_W = 32;
  localparam int TCDM_DATA_W = 32;
  localparam int TCDM_BE_W   = 4;

  // engine has one requester per memory port
  localparam int N_TCDM_PORTS = 4;
  // weight loader shares the lowest ports with the engine
  localparam int N_WL_PORTS   = 2;

  // configuration port
  localparam int CFG_ADDR_W = 8;
  localparam int CFG_DATA_W = 32;
  localparam int CFG_ID_W   = 8;

  // register word addresses
  localparam logic [CFG_ADDR_W-1:0] REG_TRIGGER   = 8'd0;
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS    = 8'd1;
  localparam logic [CFG_ADDR_W-1:0] REG_JOB_COUNT = 8'd2;

  // finished-job counter, wraps
  localparam int JOB_CNT_W = 8;

  // engine states in which the engine asks for a weight reload
  localparam int ENG_STATE_W = 4;
  localparam logic [ENG_STATE_W-1:0] ENG_WL_REQ_A = 4'b0101;
  localparam logic [ENG_STATE_W-1:0] ENG_WL_REQ_B = 4'b1001;

  // one memory request, wen high means read
  typedef struct packed {
    logic                   req;
    logic                   wen;
    logic [TCDM_ADDR_W-1:0] addr;
    logic [TCDM_BE_W-1:0]   be;
    logic [TCDM_DATA_W-1:0] wdata;
  } tcdm_req_t;

  // one memory response
  typedef struct packed {
    logic                   gnt;
    logic                   r_valid;
    logic [TCDM_DATA_W-1:0] r_data;
  } tcdm_rsp_t;

  // configuration request, wen high means read
  typedef struct packed {
    logic                  req;
    logic                  wen;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] wdata;
    logic [CFG_ID_W-1:0]   id;
  } cfg_req_t;

  // configuration response
  typedef struct packed {
    logic                  r_valid;
    logic [CFG_DATA_W-1:0] r_data;
    logic [CFG_ID_W-1:0]   r_id;
  } cfg_rsp_t;

endpackage

`default_nettype wire

// ==== src/hwce_cfg_slave.sv ====
// hwce_cfg_slave: register map, one-cycle response with id echo, trigger, busy, job count, interrupt
`timescale 1ns/1ps
`default_nettype none

module hwce_cfg_slave import hwce_pkg::*; (
  input  logic     clk_gated,
  input  logic     rst_n,
  input  cfg_req_t cfg_req_i,
  output cfg_rsp_t cfg_rsp_o,
  input  logic     job_done_i,
  output logic     trigger_o,
  output logic     evt_interrupt_o
);

  logic                  cfg_read;
  logic                  cfg_write;
  logic                  busy_q;
  logic                  evt_q;
  logic [JOB_CNT_W-1:0]  job_cnt_q;
  logic [CFG_DATA_W-1:0] reg_rdata;
  logic                  rsp_valid_q;
  logic [CFG_DATA_W-1:0] rsp_data_q;
  logic [CFG_ID_W-1:0]   rsp_id_q;

  // every request is accepted, there is no grant
  assign cfg_read  = cfg_req_i.req & cfg_req_i.wen;
  assign cfg_write = cfg_req_i.req & ~cfg_req_i.wen;

  // any write to the trigger word starts a job, unless one is running
  assign trigger_o = cfg_write & (cfg_req_i.addr == REG_TRIGGER) & ~busy_q;

  // read decode, unmapped words and the trigger word read as zero
  always_comb begin
    reg_rdata = '0;
    case (cfg_req_i.addr)
      REG_STATUS: begin
        reg_rdata[0] = busy_q;
      end
      REG_JOB_COUNT: begin
        reg_rdata[JOB_CNT_W-1:0] = job_cnt_q;
      end
      default: begin
        reg_rdata = '0;
      end
    endcase
  end

  // job status and completion count
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      job_cnt_q <= '0;
      evt_q     <= 1'b0;
    end else begin
      if (trigger_o) begin
        busy_q <= 1'b1;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
      end
      if (job_done_i) begin
        job_cnt_q <= job_cnt_q + 1'b1;
      end
      // interrupt is the done pulse delayed by one cycle
      evt_q <= job_done_i;
    end
  end

  // response valid follows each request by exactly one cycle
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.req;
    end
  end

  // response payload, captured with the request
  always_ff @(posedge clk_gated) begin
    if (cfg_req_i.req) begin
      rsp_id_q   <= cfg_req_i.id;
      rsp_data_q <= cfg_read ? reg_rdata : '0;
    end
  end

  assign cfg_rsp_o.r_valid = rsp_valid_q;
  assign cfg_rsp_o.r_data  = rsp_data_q;
  assign cfg_rsp_o.r_id    = rsp_id_q;

  assign evt_interrupt_o = evt_q;

endmodule

`default_nettype wire

// ==== src/hwce_job_seq.sv ====
// hwce_job_seq: job FSM ordering weight load before engine run, start and done pulses, working flag
`timescale 1ns/1ps
`default_nettype none

module hwce_job_seq (
  input  logic clk_gated,
  input  logic rst_n,
  input  logic trigger_i,
  input  logic wl_complete_i,
  input  logic engine_done_i,
  output logic seq_start_o,
  output logic job_done_o,
  output logic engine_start_o,
  output logic hwce_working_o
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_START,
    SEQ_RUN
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       is_working;
  logic       working_dly_q;
  logic       start_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (trigger_i) begin
          state_d = SEQ_START;
        end
      end
      // weights are loaded through the mux before the engine runs
      SEQ_START: begin
        if (wl_complete_i) begin
          state_d = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (engine_done_i) begin
          state_d = SEQ_IDLE;
        end
      end
      default: begin
        state_d = SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= SEQ_IDLE;
      start_q       <= 1'b0;
      working_dly_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      // high only on the first cycle in RUN
      start_q       <= (state_q == SEQ_START) & wl_complete_i;
      working_dly_q <= is_working;
    end
  end

  assign is_working  = (state_q != SEQ_IDLE);
  assign seq_start_o = (state_q == SEQ_START);
  assign job_done_o  = (state_q == SEQ_RUN) & engine_done_i;

  assign engine_start_o = start_q;

  // keep the gated clock alive one cycle past the end of the job
  assign hwce_working_o = is_working | working_dly_q;

endmodule

`default_nettype wire

// ==== src/hwce_tcdm_mux.sv ====
// hwce_tcdm_mux: port ownership FSM, shared-port routing, grant and response-valid masking
`timescale 1ns/1ps
`default_nettype none

module hwce_tcdm_mux import hwce_pkg::*; (
  input  logic                               clk_gated,
  input  logic                               rst_n,
  input  logic [ENG_STATE_W-1:0]             engine_state_i,
  input  logic                               seq_start_i,
  input  logic                               wl_done_i,
  input  tcdm_req_t [N_TCDM_PORTS-1:0]       eng_req_i,
  output tcdm_rsp_t [N_TCDM_PORTS-1:0]       eng_rsp_o,
  input  tcdm_req_t [N_WL_PORTS-1:0]         wl_req_i,
  output tcdm_rsp_t [N_WL_PORTS-1:0]         wl_rsp_o,
  output tcdm_req_t [N_TCDM_PORTS-1:0]       tcdm_req_o,
  input  tcdm_rsp_t [N_TCDM_PORTS-1:0]       tcdm_rsp_i,
  output logic                               wl_complete_o
);

  typedef enum logic [1:0] {
    OWN_ENGINE,
    OWN_WAIT_ENGINE,
    OWN_WEIGHTLOADER
  } owner_e;

  owner_e                    owner_q;
  owner_e                    owner_d;
  logic                      wl_req_state;
  logic                      wl_owner;
  logic [N_TCDM_PORTS-1:0]   eng_owns;
  logic [N_TCDM_PORTS-1:0]   eng_req_q;
  logic [N_WL_PORTS-1:0]     wl_req_q;

  assign wl_req_state = (engine_state_i == ENG_WL_REQ_A) | (engine_state_i == ENG_WL_REQ_B);
  assign wl_owner     = (owner_q == OWN_WEIGHTLOADER);

  always_comb begin
    owner_d = owner_q;
    case (owner_q)
      OWN_ENGINE: begin
        // at job start the engine is idle, so the ports can switch at once
        if (wl_req_state) begin
          owner_d = seq_start_i ? OWN_WEIGHTLOADER : OWN_WAIT_ENGINE;
        end
      end
      // let the engine drain its shared ports before handing them over
      OWN_WAIT_ENGINE: begin
        if (!eng_req_i[0].req && !eng_req_i[1].req) begin
          owner_d = OWN_WEIGHTLOADER;
        end
      end
      OWN_WEIGHTLOADER: begin
        if (wl_done_i) begin
          owner_d = OWN_ENGINE;
        end
      end
      default: begin
        owner_d = OWN_ENGINE;
      end
    endcase
  end

  assign wl_complete_o = wl_owner & wl_done_i;

  // static ports always belong to the engine
  always_comb begin
    for (int p = 0; p < N_TCDM_PORTS; p++) begin
      eng_owns[p] = (p >= N_WL_PORTS) | ~wl_owner;
    end
  end

  // remember which requests were actually on a port, for response-valid masking
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      owner_q   <= OWN_ENGINE;
      eng_req_q <= '0;
      wl_req_q  <= '0;
    end else begin
      owner_q <= owner_d;
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
        eng_req_q[p] <= eng_req_i[p].req & eng_owns[p];
      end
      for (int p = 0; p < N_WL_PORTS; p++) begin
        wl_req_q[p] <= wl_req_i[p].req & wl_owner;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < N_TCDM_PORTS; p++) begin
      tcdm_req_o[p]        = eng_owns[p] ? eng_req_i[p] : '0;
      eng_rsp_o[p].gnt     = tcdm_rsp_i[p].gnt & eng_req_i[p].req & eng_owns[p];
      eng_rsp_o[p].r_valid = tcdm_rsp_i[p].r_valid & eng_req_q[p];
      // read data goes to every requester of the port
      eng_rsp_o[p].r_data  = tcdm_rsp_i[p].r_data;
    end
    for (int p = 0; p < N_WL_PORTS; p++) begin
      if (wl_owner) begin
        tcdm_req_o[p] = wl_req_i[p];
      end
      wl_rsp_o[p].gnt     = tcdm_rsp_i[p].gnt & wl_req_i[p].req & wl_owner;
      wl_rsp_o[p].r_valid = tcdm_rsp_i[p].r_valid & wl_req_q[p];
      wl_rsp_o[p].r_data  = tcdm_rsp_i[p].r_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/hwce_wrapper.sv ====
// hwce_wrapper: top level joining the configuration slave, job sequencer and tcdm port mux
`timescale 1ns/1ps
`default_nettype none

module hwce_wrapper import hwce_pkg::*; (
  input  logic                         clk_gated,
  input  logic                         rst_n,

  // configuration port
  input  cfg_req_t                     cfg_req_i,
  output cfg_rsp_t                     cfg_rsp_o,

  // engine and weight-loader requesters
  input  tcdm_req_t [N_TCDM_PORTS-1:0] eng_req_i,
  output tcdm_rsp_t [N_TCDM_PORTS-1:0] eng_rsp_o,
  input  tcdm_req_t [N_WL_PORTS-1:0]   wl_req_i,
  output tcdm_rsp_t [N_WL_PORTS-1:0]   wl_rsp_o,

  // cluster memory ports
  output tcdm_req_t [N_TCDM_PORTS-1:0] tcdm_req_o,
  input  tcdm_rsp_t [N_TCDM_PORTS-1:0] tcdm_rsp_i,

  // engine control
  input  logic [ENG_STATE_W-1:0]       engine_state_i,
  input  logic                         engine_done_i,
  input  logic                         wl_done_i,
  output logic                         engine_start_o,
  output logic                         evt_interrupt_o,
  output logic                         hwce_working_o
);

  logic trigger;
  logic job_done;
  logic seq_start;
  logic wl_complete;

  hwce_cfg_slave i_cfg_slave (
    .clk_gated       ( clk_gated       ),
    .rst_n           ( rst_n           ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .job_done_i      ( job_done        ),
    .trigger_o       ( trigger         ),
    .evt_interrupt_o ( evt_interrupt_o )
  );

  hwce_job_seq i_job_seq (
    .clk_gated      ( clk_gated      ),
    .rst_n          ( rst_n          ),
    .trigger_i      ( trigger        ),
    .wl_complete_i  ( wl_complete    ),
    .engine_done_i  ( engine_done_i  ),
    .seq_start_o    ( seq_start      ),
    .job_done_o     ( job_done       ),
    .engine_start_o ( engine_start_o ),
    .hwce_working_o ( hwce_working_o )
  );

  hwce_tcdm_mux i_tcdm_mux (
    .clk_gated      ( clk_gated      ),
    .rst_n          ( rst_n          ),
    .engine_state_i ( engine_state_i ),
    .seq_start_i    ( seq_start      ),
    .wl_done_i      ( wl_done_i      ),
    .eng_req_i      ( eng_req_i      ),
    .eng_rsp_o      ( eng_rsp_o      ),
    .wl_req_i       ( wl_req_i       ),
    .wl_rsp_o       ( wl_rsp_o       ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_rsp_i     ( tcdm_rsp_i     ),
    .wl_complete_o  ( wl_complete    )
  );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// tb_clk_gen: free-running 4 ns clock and power-on reset for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for 16 cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/hwce_wrapper_asserts.sv ====
// hwce_wrapper_asserts: config response timing, interrupt width, start qualification, grant masking
`timescale 1ns/1ps
`default_nettype none

module hwce_wrapper_asserts import hwce_pkg::*; (
  input logic                         clk_gated,
  input logic                         rst_n,
  input cfg_req_t                     cfg_req_i,
  input cfg_rsp_t                     cfg_rsp_o,
  input tcdm_req_t [N_TCDM_PORTS-1:0] eng_req_i,
  input tcdm_rsp_t [N_TCDM_PORTS-1:0] eng_rsp_o,
  input tcdm_req_t [N_WL_PORTS-1:0]   wl_req_i,
  input tcdm_rsp_t [N_WL_PORTS-1:0]   wl_rsp_o,
  input logic                         engine_start_o,
  input logic                         evt_interrupt_o,
  input logic                         hwce_working_o
);

  logic [N_TCDM_PORTS-1:0] eng_stray;
  logic [N_WL_PORTS-1:0]   wl_stray;

  // a grant without a request on the same requester
  always_comb begin
    for (int p = 0; p < N_TCDM_PORTS; p++) begin
      eng_stray[p] = eng_rsp_o[p].gnt & ~eng_req_i[p].req;
    end
    for (int p = 0; p < N_WL_PORTS; p++) begin
      wl_stray[p] = wl_rsp_o[p].gnt & ~wl_req_i[p].req;
    end
  end

  a_cfg_rsp: assert property (@(posedge clk_gated) disable iff (!rst_n)
    cfg_rsp_o.r_valid == $past(cfg_req_i.req))
    else $error("config response valid does not follow its request by one cycle");

  a_irq_pulse: assert property (@(posedge clk_gated) disable iff (!rst_n)
    evt_interrupt_o |=> !evt_interrupt_o)
    else $error("event interrupt high for two cycles in a row");

  a_start_working: assert property (@(posedge clk_gated) disable iff (!rst_n)
    engine_start_o |-> hwce_working_o)
    else $error("engine start while the accelerator is not working");

  a_gnt_masked: assert property (@(posedge clk_gated) disable iff (!rst_n)
    (eng_stray == '0) && (wl_stray == '0))
    else $error("grant given to a requester without a request");

endmodule

`default_nettype wire

// ==== sim/tb_hwce_wrapper.sv ====
// tb_hwce_wrapper: table-driven testbench for the wrapper with reference checks
`timescale 1ns/1ps
`default_nettype none

module tb_hwce_wrapper import hwce_pkg::*; ();

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_JOB, OP_PROBE} op_e;
  typedef enum logic [1:0] {EV_RESET, EV_WL_PORTS, EV_START, EV_IRQ} event_e;

  // addr is the register word, or the job flags, or the probe owner mode
  typedef struct packed {
    op_e                   op;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] data;
    logic [CFG_DATA_W-1:0] exp;
  } step_t;

  logic                         clk_gated;
  logic                         rst_n;
  cfg_req_t                     cfg_req;
  cfg_rsp_t                     cfg_rsp;
  tcdm_req_t [N_TCDM_PORTS-1:0] eng_req;
  tcdm_rsp_t [N_TCDM_PORTS-1:0] eng_rsp;
  tcdm_req_t [N_WL_PORTS-1:0]   wl_req;
  tcdm_rsp_t [N_WL_PORTS-1:0]   wl_rsp;
  tcdm_req_t [N_TCDM_PORTS-1:0] tcdm_req;
  tcdm_rsp_t [N_TCDM_PORTS-1:0] tcdm_rsp;
  logic [ENG_STATE_W-1:0]       engine_state;
  logic                         engine_done;
  logic                         wl_done;
  logic                         engine_start;
  logic                         evt_interrupt;
  logic                         hwce_working;
  int                           seed = 48;
  int                           value_errors = 0;
  int                           timeouts = 0;
  logic [CFG_ID_W-1:0]          next_id = 8'h40;
  step_t                        steps [12];

  tb_clk_gen i_tb_clk_gen (
    .clk_o   ( clk_gated ),
    .rst_n_o ( rst_n     )
  );

  hwce_wrapper i_hwce_wrapper (
    .clk_gated       ( clk_gated     ),
    .rst_n           ( rst_n         ),
    .cfg_req_i       ( cfg_req       ),
    .cfg_rsp_o       ( cfg_rsp       ),
    .eng_req_i       ( eng_req       ),
    .eng_rsp_o       ( eng_rsp       ),
    .wl_req_i        ( wl_req        ),
    .wl_rsp_o        ( wl_rsp        ),
    .tcdm_req_o      ( tcdm_req      ),
    .tcdm_rsp_i      ( tcdm_rsp      ),
    .engine_state_i  ( engine_state  ),
    .engine_done_i   ( engine_done   ),
    .wl_done_i       ( wl_done       ),
    .engine_start_o  ( engine_start  ),
    .evt_interrupt_o ( evt_interrupt ),
    .hwce_working_o  ( hwce_working  )
  );

  bind hwce_wrapper hwce_wrapper_asserts i_hwce_wrapper_asserts (.*);

  task automatic check(input string name, input logic [69:0] got, input logic [69:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("** Error @ %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic logic event_seen(input event_e ev);
    case (ev)
      EV_RESET:    event_seen = (rst_n === 1'b1);
      // both shared ports carry the weight loader
      EV_WL_PORTS: event_seen = (tcdm_req[0] === wl_req[0]) && (tcdm_req[1] === wl_req[1]);
      EV_START:    event_seen = (engine_start === 1'b1);
      default:     event_seen = (evt_interrupt === 1'b1);
    endcase
  endfunction

  task automatic wait_until(input event_e ev, input string what);
    int n;
    n = 0;
    while (!event_seen(ev) && n < 64) begin
      @(negedge clk_gated);
      n++;
    end
    assert (event_seen(ev)) else begin
      timeouts++;
      $display("Timeout: no %s within 64 cycles", what);
    end
  endtask

  // one request, response checked on the following cycle
  task automatic cfg_access(input logic rd, input logic [CFG_ADDR_W-1:0] addr,
                            input logic [CFG_DATA_W-1:0] wdata,
                            input logic [CFG_DATA_W-1:0] exp);
    cfg_req = '{1'b1, rd, addr, wdata, next_id};
    @(negedge clk_gated);
    check("cfg_rsp_o.r_valid", 70'(cfg_rsp.r_valid), 70'(1'b1));
    check("cfg_rsp_o.r_id", 70'(cfg_rsp.r_id), 70'(next_id));
    check("cfg_rsp_o.r_data", 70'(cfg_rsp.r_data), 70'(exp));
    cfg_req.req = 1'b0;
    next_id = next_id + 8'd3;
  endtask

  task automatic drive_wl_reqs(input logic on);
    for (int p = 0; p < N_WL_PORTS; p++) begin
      wl_req[p] = '0;
      if (on) begin
        wl_req[p] = '{1'b1, 1'b1, 32'h0000_1000 + 32'(p), 4'hf, 32'h0};
      end
    end
  endtask

  task automatic drive_eng_shared(input logic on);
    for (int p = 0; p < N_WL_PORTS; p++) begin
      eng_req[p] = '0;
      if (on) begin
        eng_req[p] = '{1'b1, 1'b0, 32'h0000_2000 + 32'(p), 4'h3, 32'hcafe_0000};
      end
    end
  endtask

  task automatic finish_wl();
    engine_state = '0;
    drive_wl_reqs(1'b0);
    wl_done = 1'b1;
    @(negedge clk_gated);
    wl_done = 1'b0;
  endtask

  task automatic run_job(input logic twice, input logic drain, input logic [31:0] exp_count);
    int hold;
    cfg_access(1'b0, REG_TRIGGER, 32'd1, 32'd0);
    check("hwce_working_o", 70'(hwce_working), 70'(1'b1));
    engine_state = ENG_WL_REQ_A;
    drive_wl_reqs(1'b1);
    cfg_access(1'b1, REG_STATUS, 32'd0, 32'd1);
    wait_until(EV_WL_PORTS, "weight-loader ownership at job start");
    if (twice) begin
      cfg_access(1'b0, REG_TRIGGER, 32'd1, 32'd0);
    end
    finish_wl();
    wait_until(EV_START, "engine start pulse");
    @(negedge clk_gated);
    check("engine_start_o", 70'(engine_start), 70'(1'b0));
    // mid-run reload request while the engine still uses the shared ports
    if (drain) begin
      drive_eng_shared(1'b1);
      drive_wl_reqs(1'b1);
      engine_state = ENG_WL_REQ_B;
      hold = 2 + ($random(seed) & 3);
      repeat (hold) begin
        @(negedge clk_gated);
        check("tcdm_req_o[0]", 70'(tcdm_req[0]), 70'(eng_req[0]));
        check("tcdm_req_o[1]", 70'(tcdm_req[1]), 70'(eng_req[1]));
      end
      // one shared port still busy keeps both ports with the engine
      eng_req[0] = '0;
      @(negedge clk_gated);
      check("tcdm_req_o[0]", 70'(tcdm_req[0]), 70'(eng_req[0]));
      check("tcdm_req_o[1]", 70'(tcdm_req[1]), 70'(eng_req[1]));
      drive_eng_shared(1'b0);
      engine_state = '0;
      wait_until(EV_WL_PORTS, "weight-loader ownership after engine drain");
      finish_wl();
    end
    engine_done = 1'b1;
    @(negedge clk_gated);
    engine_done = 1'b0;
    wait_until(EV_IRQ, "event interrupt");
    // working stays up one cycle past the return to idle
    check("hwce_working_o", 70'(hwce_working), 70'(1'b1));
    @(negedge clk_gated);
    check("evt_interrupt_o", 70'(evt_interrupt), 70'(1'b0));
    check("hwce_working_o", 70'(hwce_working), 70'(1'b0));
    cfg_access(1'b1, REG_JOB_COUNT, 32'd0, exp_count);
  endtask

  task automatic rand_req(output tcdm_req_t r);
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    r = '{a[0], a[1], {a[31:6], b[5:0]}, a[5:2], b};
  endtask

  task automatic random_traffic(input logic wl_mode, input int cycles);
    logic [N_TCDM_PORTS-1:0] prev_eng;
    logic [N_WL_PORTS-1:0]   prev_wl;
    logic                    own;
    logic [31:0]             r;
    tcdm_req_t               exp_req;
    tcdm_rsp_t               exp_rsp;
    if (wl_mode) begin
      drive_wl_reqs(1'b1);
      engine_state = ENG_WL_REQ_A;
      @(negedge clk_gated);
      engine_state = '0;
      wait_until(EV_WL_PORTS, "weight-loader ownership for traffic");
      @(negedge clk_gated);
    end
    for (int p = 0; p < N_TCDM_PORTS; p++) begin
      prev_eng[p] = eng_req[p].req & ((p >= N_WL_PORTS) | !wl_mode);
    end
    for (int p = 0; p < N_WL_PORTS; p++) begin
      prev_wl[p] = wl_req[p].req & wl_mode;
    end
    repeat (cycles) begin
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
        rand_req(eng_req[p]);
        r = $random(seed);
        tcdm_rsp[p] = '{r[0], r[1], $random(seed)};
      end
      for (int p = 0; p < N_WL_PORTS; p++) begin
        rand_req(wl_req[p]);
      end
      #1;
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
        own = (p >= N_WL_PORTS) || !wl_mode;
        if (own) begin
          exp_req = eng_req[p];
        end else begin
          exp_req = wl_req[p];
        end
        exp_rsp = '{tcdm_rsp[p].gnt & eng_req[p].req & own,
                    tcdm_rsp[p].r_valid & prev_eng[p], tcdm_rsp[p].r_data};
        check($sformatf("tcdm_req_o[%0d]", p), 70'(tcdm_req[p]), 70'(exp_req));
        check($sformatf("eng_rsp_o[%0d]", p), 70'(eng_rsp[p]), 70'(exp_rsp));
        prev_eng[p] = eng_req[p].req & own;
      end
      for (int p = 0; p < N_WL_PORTS; p++) begin
        exp_rsp = '{tcdm_rsp[p].gnt & wl_req[p].req & wl_mode,
                    tcdm_rsp[p].r_valid & prev_wl[p], tcdm_rsp[p].r_data};
        check($sformatf("wl_rsp_o[%0d]", p), 70'(wl_rsp[p]), 70'(exp_rsp));
        prev_wl[p] = wl_req[p].req & wl_mode;
      end
      @(negedge clk_gated);
    end
    eng_req  = '0;
    wl_req   = '0;
    tcdm_rsp = '0;
    if (wl_mode) begin
      finish_wl();
    end
  endtask

  initial begin
    cfg_req      = '0;
    eng_req      = '0;
    wl_req       = '0;
    tcdm_rsp     = '0;
    engine_state = '0;
    engine_done  = 1'b0;
    wl_done      = 1'b0;
    // job flags: bit 0 second trigger, bit 1 mid-run drain
    steps[0]  = '{OP_RD, REG_STATUS, 32'd0, 32'd0};
    steps[1]  = '{OP_RD, REG_JOB_COUNT, 32'd0, 32'd0};
    steps[2]  = '{OP_RD, 8'h3c, 32'd0, 32'd0};
    steps[3]  = '{OP_WR, 8'h07, 32'hdead_beef, 32'd0};
    steps[4]  = '{OP_JOB, 8'd0, 32'd0, 32'd1};
    steps[5]  = '{OP_RD, REG_STATUS, 32'd0, 32'd0};
    steps[6]  = '{OP_JOB, 8'd3, 32'd0, 32'd2};
    steps[7]  = '{OP_RD, REG_STATUS, 32'd0, 32'd0};
    steps[8]  = '{OP_PROBE, 8'd0, 32'd40, 32'd0};
    steps[9]  = '{OP_PROBE, 8'd1, 32'd40, 32'd0};
    steps[10] = '{OP_RD, REG_JOB_COUNT, 32'd0, 32'd2};
    steps[11] = '{OP_JOB, 8'd1, 32'd0, 32'd3};
    wait_until(EV_RESET, "reset release");
    @(negedge clk_gated);
    check("engine_start_o", 70'(engine_start), 70'(1'b0));
    check("evt_interrupt_o", 70'(evt_interrupt), 70'(1'b0));
    check("hwce_working_o", 70'(hwce_working), 70'(1'b0));
    check("cfg_rsp_o.r_valid", 70'(cfg_rsp.r_valid), 70'(1'b0));
    for (int p = 0; p < N_TCDM_PORTS; p++) begin
      check($sformatf("eng_rsp_o[%0d]", p), 70'(eng_rsp[p]), 70'(0));
    end
    for (int p = 0; p < N_WL_PORTS; p++) begin
      check($sformatf("wl_rsp_o[%0d]", p), 70'(wl_rsp[p]), 70'(0));
    end
    for (int i = 0; i < 12; i++) begin
      case (steps[i].op)
        OP_WR:   cfg_access(1'b0, steps[i].addr, steps[i].data, steps[i].exp);
        OP_RD:   cfg_access(1'b1, steps[i].addr, steps[i].data, steps[i].exp);
        OP_JOB:  run_job(steps[i].addr[0], steps[i].addr[1], steps[i].exp);
        default: random_traffic(steps[i].addr[0], int'(steps[i].data));
      endcase
    end
    @(negedge clk_gated);
    $display("checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/hwce_pkg.sv
src/hwce_cfg_slave.sv
src/hwce_job_seq.sv
src/hwce_tcdm_mux.sv
src/hwce_wrapper.sv
sim/tb_clk_gen.sv
sim/hwce_wrapper_asserts.sv
sim/tb_hwce_wrapper.sv

// ==== Makefile ====
SIM_BIN := obj_dir/Vtb_hwce_wrapper

.PHONY: all run clean

all: run

$(SIM_BIN): $(wildcard src/*.sv sim/*.sv) sim.f
	verilator --binary --timing --assert -f sim.f --top-module tb_hwce_wrapper

run: $(SIM_BIN)
	./$(SIM_BIN) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
